// ==== hw/graph_ingest_macros.svh ====
`ifndef GRAPH_INGEST_MACROS_SVH
`define GRAPH_INGEST_MACROS_SVH

// Sparse identifier space, 32768 names
`define GI_NODE_STR_WIDTH 15

// Dense index space, index 0 reserved as unassigned
`define GI_MAX_NODES 1024

`define GI_DEG_WIDTH 16 // Saturating degree counts

`endif

// ==== hw/graph_ingest_pkg.sv ====
`include "graph_ingest_macros.svh"

package graph_ingest_pkg;

    typedef logic [`GI_NODE_STR_WIDTH-1:0] node_str_t;

    typedef logic [$clog2(`GI_MAX_NODES)-1:0] node_idx_t; // 0 means unassigned

    typedef logic [`GI_DEG_WIDTH-1:0] degree_t;

    // Host register map, data is 32 bits
    typedef enum logic [2:0] {
        REG_NODE_COUNT = 3'd0,
        REG_EDGE_COUNT = 3'd1,
        REG_DROP_COUNT = 3'd2,
        REG_STATUS     = 3'd3, // Bit 0 done, bit 1 full, bit 2 busy
        REG_DEG_SEL    = 3'd4,
        REG_DEG_OUT    = 3'd5,
        REG_DEG_IN     = 3'd6
    } reg_addr_e;

endpackage

// ==== hw/node_id_mapper.sv ====
`include "graph_ingest_macros.svh"

module node_id_mapper import graph_ingest_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      src_node_str_valid,
    input  logic      edge_str_valid,
    input  logic      decoding_done_str,
    input  node_str_t src_node_str,
    input  node_str_t dst_node_str,
    output logic      src_node_idx_valid,
    output logic      edge_idx_valid,
    output logic      decoding_done_idx,
    output node_idx_t src_node_idx,
    output node_idx_t dst_node_idx,
    output logic [1:0] new_node_count,
    output logic      map_busy,
    output logic      map_full
);

    localparam int IDX_W = $bits(node_idx_t);
    localparam logic [IDX_W:0] CNT_LIMIT = `GI_MAX_NODES;

    node_idx_t node_lut [2**`GI_NODE_STR_WIDTH];

    logic [IDX_W:0] next_cnt; // One extra bit so the full state is representable
    logic [IDX_W:0] cnt_mid;
    logic [IDX_W:0] cnt_next;
    node_str_t      clr_ptr;

    node_idx_t src_hit;
    node_idx_t dst_hit;
    node_idx_t src_idx_now;
    node_idx_t dst_idx_now;
    logic      src_go;
    logic      edge_go;
    logic      src_alloc;
    logic      dst_same;
    logic      dst_alloc;

    // Strobes during the clear sweep are dropped
    assign src_go  = src_node_str_valid && !map_busy;
    assign edge_go = edge_str_valid && !map_busy;

    assign src_hit = node_lut[src_node_str];
    assign dst_hit = node_lut[dst_node_str];

    assign src_alloc = src_go && (src_hit == '0) && (next_cnt < CNT_LIMIT);
    assign cnt_mid   = src_alloc ? next_cnt + 1'b1 : next_cnt; // Src takes its index first

    // Same new name on both sides shares the src index
    assign dst_same  = src_go && (dst_node_str == src_node_str);
    assign dst_alloc = edge_go && (dst_hit == '0) && !dst_same && (cnt_mid < CNT_LIMIT);
    assign cnt_next  = cnt_mid + {{IDX_W{1'b0}}, dst_alloc};

    always_comb begin
        if (src_hit != '0) begin
            src_idx_now = src_hit;
        end else if (src_alloc) begin
            src_idx_now = next_cnt[IDX_W-1:0];
        end else begin
            src_idx_now = '0; // Table full
        end
    end

    always_comb begin
        if (dst_hit != '0) begin
            dst_idx_now = dst_hit;
        end else if (dst_same) begin
            dst_idx_now = src_idx_now;
        end else if (dst_alloc) begin
            dst_idx_now = cnt_mid[IDX_W-1:0];
        end else begin
            dst_idx_now = '0;
        end
    end

    assign map_full = (next_cnt == CNT_LIMIT);

    always_ff @(posedge clk) begin
        if (rst) begin
            src_node_idx_valid <= 1'b0;
            edge_idx_valid     <= 1'b0;
            decoding_done_idx  <= 1'b0;
            src_node_idx       <= '0;
            new_node_count     <= 2'd0;
            next_cnt           <= 1;
            map_busy           <= 1'b1;
            clr_ptr            <= '0;
        end else begin
            src_node_idx_valid <= src_go;
            edge_idx_valid     <= edge_go;
            decoding_done_idx  <= decoding_done_str;
            new_node_count     <= {1'b0, src_alloc} + {1'b0, dst_alloc};
            next_cnt           <= cnt_next;
            if (src_go) begin
                src_node_idx <= src_idx_now; // Held as the source of later edges
            end
            if (map_busy) begin
                clr_ptr <= clr_ptr + 1'b1;
                if (clr_ptr == '1) begin
                    map_busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (edge_go) begin
            dst_node_idx <= dst_idx_now;
        end
    end

    always_ff @(posedge clk) begin
        if (map_busy) begin
            node_lut[clr_ptr] <= '0;
        end else begin
            if (src_alloc) begin
                node_lut[src_node_str] <= next_cnt[IDX_W-1:0];
            end
            if (dst_alloc) begin
                node_lut[dst_node_str] <= cnt_mid[IDX_W-1:0];
            end
        end
    end

    a_cnt_bound: assert property (@(posedge clk) disable iff (rst) next_cnt <= CNT_LIMIT)
        else $error("node_id_mapper: index counter past GI_MAX_NODES");

    a_no_valid_busy: assert property (@(posedge clk) disable iff (rst)
        map_busy |-> !(src_node_idx_valid || edge_idx_valid))
        else $error("node_id_mapper: valid output during clear sweep");

endmodule

// ==== hw/degree_counter.sv ====
`include "graph_ingest_macros.svh"

module degree_counter import graph_ingest_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      edge_idx_valid,
    input  node_idx_t src_node_idx,
    input  node_idx_t dst_node_idx,
    input  node_idx_t deg_sel,
    output degree_t   deg_out_val,
    output degree_t   deg_in_val,
    output logic      deg_busy
);

    degree_t out_mem [`GI_MAX_NODES];
    degree_t in_mem  [`GI_MAX_NODES];

    node_idx_t clr_ptr;
    degree_t   out_cur;
    degree_t   in_cur;
    logic      edge_ok;

    // Index 0 is unassigned, such edges carry no node
    assign edge_ok = edge_idx_valid && !deg_busy
                     && (src_node_idx != '0) && (dst_node_idx != '0);

    assign out_cur = out_mem[src_node_idx];
    assign in_cur  = in_mem[dst_node_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            clr_ptr  <= '0;
            deg_busy <= 1'b1;
        end else if (deg_busy) begin
            clr_ptr <= clr_ptr + 1'b1;
            if (clr_ptr == '1) begin
                deg_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (deg_busy) begin
            out_mem[clr_ptr] <= '0;
            in_mem[clr_ptr]  <= '0;
        end else if (edge_ok) begin
            // Self-loop lands in both memories
            if (out_cur != '1) begin
                out_mem[src_node_idx] <= out_cur + 1'b1;
            end
            if (in_cur != '1) begin
                in_mem[dst_node_idx] <= in_cur + 1'b1;
            end
        end
    end

    // Host readback port
    always_ff @(posedge clk) begin
        deg_out_val <= out_mem[deg_sel];
        deg_in_val  <= in_mem[deg_sel];
    end

    a_no_edge_busy: assert property (@(posedge clk) disable iff (rst)
        deg_busy |-> !edge_idx_valid)
        else $error("degree_counter: edge arrived during clear sweep");

endmodule

// ==== hw/ingest_regs.sv ====
module ingest_regs import graph_ingest_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        reg_wr_en,
    input  logic        reg_rd_en,
    input  reg_addr_e   reg_addr,
    input  logic [31:0] reg_wr_data,
    input  logic        src_node_str_valid,
    input  logic        edge_str_valid,
    input  logic [1:0]  new_node_count,
    input  logic        edge_idx_valid,
    input  logic        decoding_done_idx,
    input  logic        map_busy,
    input  logic        map_full,
    input  logic        deg_busy,
    input  degree_t     deg_out_val,
    input  degree_t     deg_in_val,
    output logic [31:0] reg_rd_data,
    output node_idx_t   deg_sel
);

    logic [31:0] node_count;
    logic [31:0] edge_count;
    logic [31:0] drop_count;
    logic [1:0]  drop_inc;
    logic        done_flag;
    logic        busy;

    assign busy = map_busy || deg_busy;

    // Src and edge strobes can both drop in one cycle
    assign drop_inc = {1'b0, src_node_str_valid && busy} + {1'b0, edge_str_valid && busy};

    always_ff @(posedge clk) begin
        if (rst) begin
            node_count <= '0;
            edge_count <= '0;
            drop_count <= '0;
            done_flag  <= 1'b0;
            deg_sel    <= '0;
        end else begin
            node_count <= node_count + {30'd0, new_node_count};
            edge_count <= edge_count + {31'd0, edge_idx_valid};
            drop_count <= drop_count + {30'd0, drop_inc};
            if (decoding_done_idx) begin
                done_flag <= 1'b1; // Sticky until reset
            end
            if (reg_wr_en && reg_addr == REG_DEG_SEL) begin
                deg_sel <= node_idx_t'(reg_wr_data);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_rd_data <= '0;
        end else if (reg_rd_en) begin
            case (reg_addr)
                REG_NODE_COUNT: reg_rd_data <= node_count;
                REG_EDGE_COUNT: reg_rd_data <= edge_count;
                REG_DROP_COUNT: reg_rd_data <= drop_count;
                REG_STATUS:     reg_rd_data <= {29'd0, busy, map_full, done_flag};
                REG_DEG_SEL:    reg_rd_data <= 32'(deg_sel);
                REG_DEG_OUT:    reg_rd_data <= 32'(deg_out_val);
                REG_DEG_IN:     reg_rd_data <= 32'(deg_in_val);
                default:        reg_rd_data <= '0;
            endcase
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(reg_wr_en && reg_rd_en))
        else $error("ingest_regs: read and write strobes together");

endmodule

// ==== hw/graph_ingest_top.sv ====
module graph_ingest_top import graph_ingest_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        src_node_str_valid,
    input  logic        edge_str_valid,
    input  logic        decoding_done_str,
    input  node_str_t   src_node_str,
    input  node_str_t   dst_node_str,
    output logic        src_node_idx_valid,
    output logic        edge_idx_valid,
    output logic        decoding_done_idx,
    output node_idx_t   src_node_idx,
    output node_idx_t   dst_node_idx,
    input  logic        reg_wr_en,
    input  logic        reg_rd_en,
    input  reg_addr_e   reg_addr,
    input  logic [31:0] reg_wr_data,
    output logic [31:0] reg_rd_data
);

    logic [1:0] new_node_count;
    logic       map_busy;
    logic       map_full;
    logic       deg_busy;
    node_idx_t  deg_sel;
    degree_t    deg_out_val;
    degree_t    deg_in_val;

    node_id_mapper i_mapper (
        .clk, .rst,
        .src_node_str_valid, .edge_str_valid, .decoding_done_str,
        .src_node_str, .dst_node_str,
        .src_node_idx_valid, .edge_idx_valid, .decoding_done_idx,
        .src_node_idx, .dst_node_idx,
        .new_node_count, .map_busy, .map_full
    );

    degree_counter i_degree (
        .clk, .rst,
        .edge_idx_valid, .src_node_idx, .dst_node_idx,
        .deg_sel, .deg_out_val, .deg_in_val, .deg_busy
    );

    // Host side, raw strobes feed the drop counter
    ingest_regs i_regs (
        .clk, .rst,
        .reg_wr_en, .reg_rd_en, .reg_addr, .reg_wr_data,
        .src_node_str_valid, .edge_str_valid,
        .new_node_count, .edge_idx_valid, .decoding_done_idx,
        .map_busy, .map_full, .deg_busy,
        .deg_out_val, .deg_in_val,
        .reg_rd_data, .deg_sel
    );

endmodule

// ==== tests/tb_graph_ingest.sv ====
`include "graph_ingest_macros.svh"

module tb_graph_ingest import graph_ingest_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [1:0] OP_SRC  = 2'd0;
    localparam logic [1:0] OP_EDGE = 2'd1;
    localparam logic [1:0] OP_BOTH = 2'd2; // Src and edge strobes in one cycle
    localparam logic [1:0] OP_DONE = 2'd3;
    localparam int NUM_ROWS   = 24;
    localparam int NUM_DROPS  = 4;
    localparam int NUM_RAND   = 60;
    localparam int IDLE_POLLS = (1 << `GI_NODE_STR_WIDTH) + 1000; // Mapper sweep is the longest

    logic        clk;
    logic        rst;
    logic        src_node_str_valid;
    logic        edge_str_valid;
    logic        decoding_done_str;
    node_str_t   src_node_str;
    node_str_t   dst_node_str;
    logic        src_node_idx_valid;
    logic        edge_idx_valid;
    logic        decoding_done_idx;
    node_idx_t   src_node_idx;
    node_idx_t   dst_node_idx;
    logic        reg_wr_en;
    logic        reg_rd_en;
    reg_addr_e   reg_addr;
    logic [31:0] reg_wr_data;
    logic [31:0] reg_rd_data;

    // Op, src id, dst id, expected src index and expected dst index per row
    logic [51:0] stim_table [NUM_ROWS] = '{
        {OP_SRC,  15'h0100, 15'h0000, 10'd1,  10'd0},
        {OP_EDGE, 15'h0000, 15'h0200, 10'd1,  10'd2},
        {OP_EDGE, 15'h0000, 15'h0200, 10'd1,  10'd2},  // Repeat
        {OP_SRC,  15'h0200, 15'h0000, 10'd2,  10'd0},
        {OP_EDGE, 15'h0000, 15'h0100, 10'd2,  10'd1},
        {OP_BOTH, 15'h0300, 15'h0400, 10'd3,  10'd4},  // Two new ids at once
        {OP_BOTH, 15'h0500, 15'h0500, 10'd5,  10'd5},  // Same new id shares an index
        {OP_EDGE, 15'h0000, 15'h0500, 10'd5,  10'd5},
        {OP_SRC,  15'h7fff, 15'h0000, 10'd6,  10'd0},
        {OP_EDGE, 15'h0000, 15'h0000, 10'd6,  10'd7},
        {OP_BOTH, 15'h0100, 15'h1234, 10'd1,  10'd8},
        {OP_BOTH, 15'h2222, 15'h0300, 10'd9,  10'd3},
        {OP_SRC,  15'h0400, 15'h0000, 10'd4,  10'd0},
        {OP_EDGE, 15'h0000, 15'h0400, 10'd4,  10'd4},  // Self-loop
        {OP_EDGE, 15'h0000, 15'h3333, 10'd4,  10'd10},
        {OP_BOTH, 15'h4444, 15'h5555, 10'd11, 10'd12},
        {OP_SRC,  15'h5555, 15'h0000, 10'd12, 10'd0},
        {OP_EDGE, 15'h0000, 15'h4444, 10'd12, 10'd11},
        {OP_BOTH, 15'h0200, 15'h0200, 10'd2,  10'd2},
        {OP_EDGE, 15'h0000, 15'h0001, 10'd2,  10'd13},
        {OP_SRC,  15'h0001, 15'h0000, 10'd13, 10'd0},
        {OP_EDGE, 15'h0000, 15'h0100, 10'd13, 10'd1},
        {OP_BOTH, 15'h6000, 15'h0001, 10'd14, 10'd13},
        {OP_DONE, 15'h0000, 15'h0000, 10'd0,  10'd0}
    };

    // Reference model state
    int     id_map [int];
    int     out_deg [`GI_MAX_NODES];
    int     in_deg [`GI_MAX_NODES];
    int     next_idx;
    int     cur_src;
    int     edge_total;
    int     mism_count;
    int     other_count;
    integer seed;

    graph_ingest_top i_dut (
        .clk, .rst,
        .src_node_str_valid, .edge_str_valid, .decoding_done_str,
        .src_node_str, .dst_node_str,
        .src_node_idx_valid, .edge_idx_valid, .decoding_done_idx,
        .src_node_idx, .dst_node_idx,
        .reg_wr_en, .reg_rd_en, .reg_addr, .reg_wr_data, .reg_rd_data
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            mism_count++;
            $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic model_step(input logic [1:0] op, input int s, input int d,
                              output int exp_s, output int exp_d);
        exp_s = 0;
        exp_d = 0;
        if (op == OP_SRC || op == OP_BOTH) begin
            if (!id_map.exists(s)) begin
                id_map[s] = next_idx;
                next_idx++;
            end
            cur_src = id_map[s];
            exp_s = cur_src;
        end
        // Src goes first, so a same-id dst finds it already mapped
        if (op == OP_EDGE || op == OP_BOTH) begin
            if (!id_map.exists(d)) begin
                id_map[d] = next_idx;
                next_idx++;
            end
            exp_s = cur_src;
            exp_d = id_map[d];
            edge_total++;
            if (cur_src != 0) begin
                out_deg[cur_src]++;
                in_deg[exp_d]++;
            end
        end
    endtask

    task automatic apply_op(input logic [1:0] op, input node_str_t s, input node_str_t d,
                            input logic use_tab, input int tab_s, input int tab_d);
        int   exp_s;
        int   exp_d;
        logic want_src;
        logic want_edge;
        model_step(op, int'(s), int'(d), exp_s, exp_d);
        want_src  = (op == OP_SRC || op == OP_BOTH);
        want_edge = (op == OP_EDGE || op == OP_BOTH);
        if (use_tab) begin
            check_value("table src index vs model", exp_s, tab_s);
            check_value("table dst index vs model", exp_d, tab_d);
        end
        src_node_str_valid = want_src;
        edge_str_valid     = want_edge;
        decoding_done_str  = (op == OP_DONE);
        src_node_str       = s;
        dst_node_str       = d;
        @(posedge clk);
        #1;
        src_node_str_valid = 1'b0;
        edge_str_valid     = 1'b0;
        decoding_done_str  = 1'b0;
        check_value("src_node_idx_valid", src_node_idx_valid, want_src);
        check_value("edge_idx_valid", edge_idx_valid, want_edge);
        check_value("decoding_done_idx", decoding_done_idx, op == OP_DONE);
        if (want_src || want_edge) begin
            check_value($sformatf("src index for id %0h", s), src_node_idx, exp_s);
        end
        if (want_edge) begin
            check_value($sformatf("dst index for id %0h", d), dst_node_idx, exp_d);
        end
        @(posedge clk);
        #1;
        check_value("src_node_idx_valid one cycle later", src_node_idx_valid, 0);
        check_value("edge_idx_valid one cycle later", edge_idx_valid, 0);
        check_value("decoding_done_idx one cycle later", decoding_done_idx, 0);
    endtask

    task automatic reg_write(input reg_addr_e addr, input logic [31:0] data);
        reg_wr_en   = 1'b1;
        reg_addr    = addr;
        reg_wr_data = data;
        @(posedge clk);
        #1;
        reg_wr_en = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_e addr, output logic [31:0] data);
        reg_rd_en = 1'b1;
        reg_addr  = addr;
        @(posedge clk);
        #1;
        reg_rd_en = 1'b0;
        data = reg_rd_data;
    endtask

    // Src only, edge only, then both during the sweep
    task automatic inject_drops();
        int k;
        for (k = 0; k < 3; k++) begin
            src_node_str_valid = (k != 1);
            edge_str_valid     = (k != 0);
            src_node_str       = (k == 0) ? 15'h0100 : 15'h0300;
            dst_node_str       = (k == 1) ? 15'h0200 : 15'h0400;
            @(posedge clk);
            #1;
            check_value("src valid during sweep", src_node_idx_valid, 0);
            check_value("edge valid during sweep", edge_idx_valid, 0);
        end
        src_node_str_valid = 1'b0;
        edge_str_valid     = 1'b0;
    endtask

    task automatic wait_idle(output logic ok);
        logic [31:0] status;
        int          polls;
        ok = 1'b0;
        for (polls = 0; polls < IDLE_POLLS && !ok; polls++) begin
            reg_read(REG_STATUS, status);
            if (polls == 0) begin
                check_value("busy bit right after reset", status[2], 1);
            end
            ok = !status[2];
        end
        assert (ok) else begin
            other_count++;
            $display("Timed out waiting for the clear sweep to finish");
        end
    endtask

    task automatic check_counters(input logic [31:0] exp_status);
        logic [31:0] val;
        reg_read(REG_NODE_COUNT, val);
        check_value("node count", val, next_idx - 1);
        reg_read(REG_EDGE_COUNT, val);
        check_value("edge count", val, edge_total);
        reg_read(REG_DROP_COUNT, val);
        check_value("drop count", val, NUM_DROPS);
        reg_read(REG_STATUS, val);
        check_value("status", val, exp_status);
    endtask

    task automatic check_degrees();
        logic [31:0] val;
        int          i;
        for (i = 0; i <= next_idx; i++) begin
            reg_write(REG_DEG_SEL, i);
            reg_read(REG_DEG_SEL, val);
            check_value("degree select readback", val, i);
            reg_read(REG_DEG_OUT, val);
            check_value($sformatf("out degree of index %0d", i), val, out_deg[i]);
            reg_read(REG_DEG_IN, val);
            check_value($sformatf("in degree of index %0d", i), val, in_deg[i]);
        end
    endtask

    initial begin
        logic        ok;
        logic [51:0] row;
        int          r;
        int          n;
        seed = 32'hcba1d370;
        next_idx = 1;
        cur_src = 0;
        edge_total = 0;
        mism_count = 0;
        other_count = 0;
        rst = 1'b1;
        src_node_str_valid = 1'b0;
        edge_str_valid = 1'b0;
        decoding_done_str = 1'b0;
        src_node_str = '0;
        dst_node_str = '0;
        reg_wr_en = 1'b0;
        reg_rd_en = 1'b0;
        reg_addr = REG_NODE_COUNT;
        reg_wr_data = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        inject_drops();
        wait_idle(ok);
        if (ok) begin
            check_counters(32'h0);
            for (n = 0; n < NUM_ROWS; n++) begin
                row = stim_table[n];
                apply_op(row[51:50], row[49:35], row[34:20], 1'b1, row[19:10], row[9:0]);
            end
            check_counters(32'h1); // Done set, not full, idle
            check_degrees();
            // Small pool of 16 ids keeps repeats frequent
            for (n = 0; n < NUM_RAND; n++) begin
                r = $random(seed);
                apply_op(r[8] ? OP_BOTH : OP_EDGE, 15'h0800 | r[3:0], 15'h0800 | r[7:4],
                         1'b0, 0, 0);
            end
            check_counters(32'h1);
            check_degrees();
        end
        $display("Errors: %0d mismatches, %0d other failures", mism_count, other_count);
        if (mism_count == 0 && other_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+hw
hw/graph_ingest_pkg.sv
hw/node_id_mapper.sv
hw/degree_counter.sv
hw/ingest_regs.sv
hw/graph_ingest_top.sv
tests/tb_graph_ingest.sv

// ==== Bender.yml ====
package:
  name: graph_ingest

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/graph_ingest_pkg.sv
      - hw/node_id_mapper.sv
      - hw/degree_counter.sv
      - hw/ingest_regs.sv
      - hw/graph_ingest_top.sv
  - target: test
    files:
      - tests/tb_graph_ingest.sv
